//--- Bender.yml
package:
  name: conv_layer

sources:
  - verilog/conv_pkg.sv
  - verilog/conv_ctrl.sv
  - verilog/window_buffer.sv
  - verilog/kernel_store.sv
  - verilog/conv_mac.sv
  - verilog/conv_layer.sv
  - target: simulation
    files:
      - verif/conv_layer_tb.sv

//--- project.f
verilog/conv_pkg.sv
verilog/conv_ctrl.sv
verilog/window_buffer.sv
verilog/kernel_store.sv
verilog/conv_mac.sv
verilog/conv_layer.sv
verif/conv_layer_tb.sv

//--- verif/conv_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_layer_tb;
    import conv_pkg::*;

    localparam int PIXELS        = IFM_SIZE * IFM_SIZE;
    localparam int OUTPUTS       = OFM_SIZE * OFM_SIZE;
    localparam int WAIT_LIMIT    = 400;
    localparam int SIG_NEXT_REQ  = 0;
    localparam int SIG_START_ACK = 1;
    localparam int SIG_READY     = 2;

    logic      clk = 1'b0;
    logic      reset;
    logic      ifm_rd_en;
    ifm_addr_t ifm_rd_addr;
    pixel_t    ifm_rd_data;
    logic      wt_wr_en;
    wt_addr_t  wt_wr_addr;
    weight_t   wt_wr_data;
    logic      bias_wr_en;
    filter_t   bias_wr_addr;
    bias_t     bias_wr_data;
    logic      ofm_wr_en;
    ofm_addr_t ofm_wr_addr;
    acc_t      ofm_wr_data;
    logic      ofm_bank;
    logic      start_req;
    logic      start_ack;
    logic      next_req;
    logic      next_ack;
    logic      ready;

    pixel_t  pix_mem  [0:PIXELS-1];
    weight_t wt_ref   [0:NUM_FILTERS*WINDOW_TAPS-1];
    bias_t   bias_ref [0:NUM_FILTERS-1];
    acc_t    bank_mem [0:1][0:OUTPUTS-1];

    integer seed;
    int     ack_delay;
    int     ack_count;
    int     read_count;
    int     errors;
    int     errors_at_start;
    int     tests_passed;
    int     tests_failed;
    logic   expected_bank;

    conv_layer dut (
        .clk(clk), .reset(reset),
        .ifm_rd_en(ifm_rd_en), .ifm_rd_addr(ifm_rd_addr), .ifm_rd_data(ifm_rd_data),
        .wt_wr_en(wt_wr_en), .wt_wr_addr(wt_wr_addr), .wt_wr_data(wt_wr_data),
        .bias_wr_en(bias_wr_en), .bias_wr_addr(bias_wr_addr), .bias_wr_data(bias_wr_data),
        .ofm_wr_en(ofm_wr_en), .ofm_wr_addr(ofm_wr_addr), .ofm_wr_data(ofm_wr_data),
        .ofm_bank(ofm_bank),
        .start_req(start_req), .start_ack(start_ack),
        .next_req(next_req), .next_ack(next_ack), .ready(ready)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Memory models, downstream responder and monitors
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (ifm_rd_en)
            ifm_rd_data <= pix_mem[ifm_rd_addr];  // one cycle latency
        if (ofm_wr_en)
            bank_mem[ofm_bank][ofm_wr_addr] <= ofm_wr_data;
    end

    always @(posedge clk)
    begin
        if (!next_req)
        begin
            next_ack  <= 1'b0;
            ack_count <= 0;
        end
        else if (!next_ack)
        begin
            if (ack_count >= ack_delay)
                next_ack <= 1'b1;
            else
                ack_count <= ack_count + 1;
        end
    end

    // Read order and reads during a downstream handshake
    always @(posedge clk)
    begin
        if (ifm_rd_en)
        begin
            if (ifm_rd_addr != read_count % PIXELS)
                report_error($sformatf("read address %0d expected %0d",
                    ifm_rd_addr, read_count % PIXELS));
            if (next_req || next_ack)
                report_error("read during a downstream handshake");
            read_count <= read_count + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_error(input string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    function automatic logic probe(input int which);
        case (which)
            SIG_NEXT_REQ:  probe = next_req;
            SIG_START_ACK: probe = start_ack;
            SIG_READY:     probe = ready;
            default:       probe = 1'b0;
        endcase
    endfunction

    // Levels are sampled on the falling edge
    task automatic wait_level(input int which, input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (probe(which) !== level && cycles < WAIT_LIMIT)
        begin
            cycles++;
            @(negedge clk);
        end
        if (probe(which) !== level)
        begin
            $display("Timeout at %0t: %s did not become %0d", $time, what, level);
            $display("TEST FAILED");
            $finish;
        end
    endtask

    // Sum of nine products plus bias wrapped to the output width
    function automatic acc_t expected_out(input int f, input int r, input int c);
        int acc;
        int ky;
        int kx;
        acc = bias_ref[f];
        for (ky = 0; ky < KERNEL_SIZE; ky++)
            for (kx = 0; kx < KERNEL_SIZE; kx++)
                acc += pix_mem[(r+ky)*IFM_SIZE + c + kx]
                       * wt_ref[f*WINDOW_TAPS + ky*KERNEL_SIZE + kx];
        return acc[ACC_W-1:0];
    endfunction

    task automatic clear_banks;
        for (int b = 0; b < 2; b++)
            for (int a = 0; a < OUTPUTS; a++)
                bank_mem[b][a] = 20'h80000 | (b << 8) | a;
    endtask

    task automatic check_bank(input int f, input int bank);
        acc_t exp_val;
        for (int r = 0; r < OFM_SIZE; r++)
            for (int c = 0; c < OFM_SIZE; c++)
            begin
                exp_val = expected_out(f, r, c);
                if (bank_mem[bank][r*OFM_SIZE + c] !== exp_val)
                    report_error($sformatf("filter %0d bank %0d addr %0d got %0d expected %0d",
                        f, bank, r*OFM_SIZE + c, bank_mem[bank][r*OFM_SIZE + c], exp_val));
            end
    endtask

    task automatic load_kernels;
        wait_level(SIG_READY, 1'b1, "ready before load");
        for (int i = 0; i < NUM_FILTERS*WINDOW_TAPS; i++)
        begin
            @(posedge clk);
            wt_wr_en   <= 1'b1;
            wt_wr_addr <= wt_addr_t'(i);
            wt_wr_data <= wt_ref[i];
        end
        @(posedge clk);
        wt_wr_en <= 1'b0;
        for (int f = 0; f < NUM_FILTERS; f++)
        begin
            bias_wr_en   <= 1'b1;
            bias_wr_addr <= filter_t'(f);
            bias_wr_data <= bias_ref[f];
            @(posedge clk);
        end
        bias_wr_en <= 1'b0;
    endtask

    task automatic randomize_layer(input logic new_weights);
        for (int a = 0; a < PIXELS; a++)
            pix_mem[a] = $random(seed);
        if (new_weights)
        begin
            for (int i = 0; i < NUM_FILTERS*WINDOW_TAPS; i++)
                wt_ref[i] = $random(seed);
            for (int f = 0; f < NUM_FILTERS; f++)
                bias_ref[f] = $random(seed) % 2048;
        end
    endtask

    // One frame is a pass per filter and then the upstream release
    task automatic run_frame(input int hold_cycles);
        int f;
        clear_banks();
        read_count = 0;
        if (start_ack !== 1'b0)
            report_error("start_ack still high at frame start");
        @(posedge clk);
        start_req <= 1'b1;
        for (f = 0; f < NUM_FILTERS; f++)
        begin
            wait_level(SIG_NEXT_REQ, 1'b1, "next_req");
            if (start_ack !== 1'b0)
                report_error($sformatf("start_ack high at next_req of pass %0d", f));
            if (read_count != PIXELS*(f+1))
                report_error($sformatf("pass %0d read count %0d", f, read_count));
            if (ofm_bank !== ~expected_bank)
                report_error($sformatf("ofm_bank did not toggle after pass %0d", f));
            check_bank(f, expected_bank);
            expected_bank = ~expected_bank;
            wait_level(SIG_NEXT_REQ, 1'b0, "next_req release");
        end
        wait_level(SIG_START_ACK, 1'b1, "start_ack");
        if (ready !== 1'b0)
            report_error("ready high while start_ack is up");
        // No new frame may start while upstream still holds start_req
        repeat (hold_cycles)
        begin
            @(negedge clk);
            if (ifm_rd_en !== 1'b0 || start_ack !== 1'b1)
                report_error("frame restarted before start_req fell");
        end
        @(posedge clk);
        start_req <= 1'b0;
        wait_level(SIG_START_ACK, 1'b0, "start_ack release");
        wait_level(SIG_READY, 1'b1, "ready after frame");
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start)
        begin
            tests_passed++;
            $display("%s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: failed, %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state;
        @(negedge clk);
        if (ifm_rd_en !== 1'b0 || ofm_wr_en !== 1'b0 || next_req !== 1'b0)
            report_error("read, write or next_req not low after reset");
        if (start_ack !== 1'b0 || ofm_bank !== 1'b0)
            report_error("start_ack or ofm_bank not low after reset");
        if (ready !== 1'b1)
            report_error("ready not high after reset");
        finish_test("reset state");
    endtask

    task automatic test_ramp_identity;
        for (int a = 0; a < PIXELS; a++)
            pix_mem[a] = pixel_t'(a);
        for (int k = 0; k < WINDOW_TAPS; k++)
        begin
            wt_ref[k]               = (k == WINDOW_TAPS/2) ? 8'sd1 : 8'sd0;  // centre tap
            wt_ref[WINDOW_TAPS + k] = weight_t'(k - 4);
        end
        bias_ref[0] = 20'sd5;
        bias_ref[1] = -20'sd3;
        load_kernels();
        run_frame(0);
        finish_test("ramp with identity kernel");
    endtask

    task automatic test_random_frame;
        randomize_layer(1'b1);
        load_kernels();
        run_frame(0);
        finish_test("random full frame");
    endtask

    // Reads during the slow handshake are flagged by the read monitor
    task automatic test_back_pressure;
        ack_delay = 20;
        randomize_layer(1'b1);
        load_kernels();
        run_frame(0);
        ack_delay = 2;
        finish_test("back-pressure");
    endtask

    task automatic test_two_frames;
        randomize_layer(1'b1);
        load_kernels();
        run_frame(0);
        randomize_layer(1'b0);  // new pixels, same kernels
        run_frame(5);
        finish_test("two frames");
    endtask

    initial
    begin
        seed            = 32'ha04e;
        ack_delay       = 2;
        ack_count       = 0;
        read_count      = 0;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        expected_bank   = 1'b0;
        reset           = 1'b1;
        ifm_rd_data     = '0;
        wt_wr_en        = 1'b0;
        wt_wr_addr      = '0;
        wt_wr_data      = '0;
        bias_wr_en      = 1'b0;
        bias_wr_addr    = '0;
        bias_wr_data    = '0;
        start_req       = 1'b0;
        next_ack        = 1'b0;

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        test_reset_state();
        test_ramp_identity();
        test_random_frame();
        test_back_pressure();
        test_two_frames();

        $display("%0d tests: %0d passed, %0d failed, %0d errors",
            tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/conv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 start_req,
    input  wire                 next_ack,
    output logic                start_ack,
    output logic                next_req,
    output logic                ready,
    output logic                ifm_rd_en,
    output conv_pkg::ifm_addr_t ifm_rd_addr,
    output logic                shift,
    output conv_pkg::filter_t   filter_sel,
    output logic                window_valid,
    output conv_pkg::ofm_addr_t ofm_wr_addr,
    output logic                ofm_bank
);
    import conv_pkg::*;

    typedef enum logic [2:0] {idle, wait_next, read, drain, ack_up} state_t;
    typedef enum logic [1:0] {ds_idle, ds_req, ds_release} ds_state_t;

    state_t    state;
    state_t    state_next;
    ds_state_t ds_state;

    logic [$clog2(IFM_SIZE)-1:0] row;
    logic [$clog2(IFM_SIZE)-1:0] col;
    logic [$clog2(IFM_SIZE)-1:0] row_d;
    logic [$clog2(IFM_SIZE)-1:0] col_d;
    logic last_addr;
    logic last_filter;
    logic valid_d;
    logic last_write;
    logic pass_done;
    logic ds_free;

    assign last_addr   = (ifm_rd_addr == ifm_addr_t'(IFM_SIZE*IFM_SIZE-1));
    assign last_filter = (filter_sel == filter_t'(NUM_FILTERS-1));
    assign last_write  = valid_d && (ofm_wr_addr == ofm_addr_t'(OFM_SIZE*OFM_SIZE-1));
    assign ds_free     = (ds_state == ds_idle) && !next_ack;

    ////////////////////////////////////////////////////////////////////////////
    // Pass sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            state <= idle;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            idle:      if (start_req) state_next = ds_free ? read : wait_next;
            wait_next: if (ds_free) state_next = read;
            read:      if (last_addr) state_next = drain;
            drain:     if (pass_done) state_next = last_filter ? ack_up : wait_next;
            ack_up:    if (!start_req) state_next = idle;  // upstream released
            default:   state_next = idle;
        endcase
    end

    assign ready     = (state == idle);
    assign ifm_rd_en = (state == read);
    assign start_ack = (state == ack_up);

    // Read address with its row and column
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            ifm_rd_addr <= '0;
            row         <= '0;
            col         <= '0;
            filter_sel  <= '0;
        end
        else
        begin
            if (ifm_rd_en)
            begin
                ifm_rd_addr <= last_addr ? '0 : ifm_rd_addr + 1'b1;
                col         <= (col == IFM_SIZE-1) ? '0 : col + 1'b1;
                if (col == IFM_SIZE-1)
                    row <= (row == IFM_SIZE-1) ? '0 : row + 1'b1;
            end
            if (state == drain && pass_done)
                filter_sel <= last_filter ? '0 : filter_sel + 1'b1;
        end
    end

    // Row and column of the pixel arriving from memory
    always_ff @(posedge clk)
    begin
        row_d <= row;
        col_d <= col;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            shift        <= 1'b0;
            window_valid <= 1'b0;
            valid_d      <= 1'b0;
            ofm_wr_addr  <= '0;
            pass_done    <= 1'b0;
        end
        else
        begin
            shift        <= ifm_rd_en;
            window_valid <= shift && (row_d >= KERNEL_SIZE-1) && (col_d >= KERNEL_SIZE-1);
            valid_d      <= window_valid;  // lines up with ofm_wr_en
            pass_done    <= last_write;
            if (valid_d)
                ofm_wr_addr <= ofm_wr_addr + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Downstream handshake and bank select
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            ds_state <= ds_idle;
            ofm_bank <= 1'b0;
        end
        else
        begin
            case (ds_state)
                ds_idle:    if (last_write) ds_state <= ds_req;
                ds_req:     if (next_ack) ds_state <= ds_release;
                ds_release: if (!next_ack) ds_state <= ds_idle;
                default:    ds_state <= ds_idle;
            endcase
            if (last_write)
                ofm_bank <= ~ofm_bank;
        end
    end

    assign next_req = (ds_state == ds_req);

    addr_in_range: assert property (@(posedge clk) disable iff (reset)
        ifm_rd_en |-> ifm_rd_addr < IFM_SIZE*IFM_SIZE);

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(start_ack) |-> start_req);

    // A pass never starts into a busy consumer
    pass_after_release: assert property (@(posedge clk) disable iff (reset)
        $rose(ifm_rd_en) |-> !(next_req && !next_ack));

endmodule

`default_nettype wire

//--- verilog/conv_layer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_layer
(
    input  wire                      clk,
    input  wire                      reset,
    // Input map memory
    output wire                      ifm_rd_en,
    output wire conv_pkg::ifm_addr_t ifm_rd_addr,
    input  wire conv_pkg::pixel_t    ifm_rd_data,
    // Weight and bias load
    input  wire                      wt_wr_en,
    input  wire conv_pkg::wt_addr_t  wt_wr_addr,
    input  wire conv_pkg::weight_t   wt_wr_data,
    input  wire                      bias_wr_en,
    input  wire conv_pkg::filter_t   bias_wr_addr,
    input  wire conv_pkg::bias_t     bias_wr_data,
    // Output banks
    output wire                      ofm_wr_en,
    output wire conv_pkg::ofm_addr_t ofm_wr_addr,
    output wire conv_pkg::acc_t      ofm_wr_data,
    output wire                      ofm_bank,
    // Handshakes and status
    input  wire                      start_req,
    output wire                      start_ack,
    output wire                      next_req,
    input  wire                      next_ack,
    output wire                      ready
);
    import conv_pkg::*;

    logic                      shift;
    logic                      window_valid;
    filter_t                   filter_sel;
    pixel_t [WINDOW_TAPS-1:0]  window;
    weight_t [WINDOW_TAPS-1:0] kernel;
    bias_t                     bias;

    conv_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .start_req(start_req), .next_ack(next_ack),
        .start_ack(start_ack), .next_req(next_req), .ready(ready),
        .ifm_rd_en(ifm_rd_en), .ifm_rd_addr(ifm_rd_addr), .shift(shift),
        .filter_sel(filter_sel), .window_valid(window_valid),
        .ofm_wr_addr(ofm_wr_addr), .ofm_bank(ofm_bank)
    );

    window_buffer u_window (
        .clk(clk), .reset(reset),
        .pixel_in(ifm_rd_data), .shift(shift), .window(window)
    );

    kernel_store u_kernel (
        .clk(clk), .reset(reset),
        .wt_wr_en(wt_wr_en), .wt_wr_addr(wt_wr_addr), .wt_wr_data(wt_wr_data),
        .bias_wr_en(bias_wr_en), .bias_wr_addr(bias_wr_addr), .bias_wr_data(bias_wr_data),
        .filter_sel(filter_sel), .kernel(kernel), .bias(bias)
    );

    conv_mac u_mac (
        .clk(clk), .reset(reset),
        .window(window), .kernel(kernel), .bias(bias), .window_valid(window_valid),
        .ofm_wr_en(ofm_wr_en), .ofm_wr_data(ofm_wr_data)
    );

endmodule

`default_nettype wire

//--- verilog/conv_mac.sv
`timescale 1ns/1ps
`default_nettype none

module conv_mac
(
    input  wire                                                 clk,
    input  wire                                                 reset,
    input  wire conv_pkg::pixel_t [conv_pkg::WINDOW_TAPS-1:0]   window,
    input  wire conv_pkg::weight_t [conv_pkg::WINDOW_TAPS-1:0]  kernel,
    input  wire conv_pkg::bias_t                                bias,
    input  wire                                                 window_valid,
    output logic                                                ofm_wr_en,
    output conv_pkg::acc_t                                      ofm_wr_data
);
    import conv_pkg::*;

    acc_t sum;

    // Nine products plus bias, sign extended to the sum width
    always_comb
    begin
        sum = bias;
        for (int k = 0; k < WINDOW_TAPS; k++)
            sum = sum + acc_t'(window[k]) * acc_t'(kernel[k]);
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            ofm_wr_en <= 1'b0;
        else
            ofm_wr_en <= window_valid;  // one write per valid window
    end

    always_ff @(posedge clk)
    begin
        if (window_valid)
            ofm_wr_data <= sum;
    end

    write_data_known: assert property (@(posedge clk) disable iff (reset)
        ofm_wr_en |-> !$isunknown(ofm_wr_data));

endmodule

`default_nettype wire

//--- verilog/conv_pkg.sv
`default_nettype none

package conv_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Layer geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int IFM_SIZE    = 6;
    localparam int KERNEL_SIZE = 3;
    localparam int NUM_FILTERS = 2;
    localparam int OFM_SIZE    = IFM_SIZE - KERNEL_SIZE + 1;
    localparam int WINDOW_TAPS = KERNEL_SIZE * KERNEL_SIZE;
    localparam int LINE_DEPTH  = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;

    // Data widths
    localparam int PIXEL_W  = 8;
    localparam int WEIGHT_W = 8;
    localparam int ACC_W    = 20;

    ////////////////////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [PIXEL_W-1:0]  pixel_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [ACC_W-1:0]    bias_t;
    typedef logic signed [ACC_W-1:0]    acc_t;

    typedef logic [$clog2(IFM_SIZE*IFM_SIZE)-1:0]    ifm_addr_t;
    typedef logic [$clog2(OFM_SIZE*OFM_SIZE)-1:0]    ofm_addr_t;
    typedef logic [$clog2(NUM_FILTERS*WINDOW_TAPS)-1:0] wt_addr_t;  // filter * taps + tap
    typedef logic [$clog2(NUM_FILTERS)-1:0]          filter_t;

endpackage

`default_nettype wire

//--- verilog/kernel_store.sv
`timescale 1ns/1ps
`default_nettype none

module kernel_store
(
    input  wire                                            clk,
    input  wire                                            reset,
    input  wire                                            wt_wr_en,
    input  wire conv_pkg::wt_addr_t                        wt_wr_addr,
    input  wire conv_pkg::weight_t                         wt_wr_data,
    input  wire                                            bias_wr_en,
    input  wire conv_pkg::filter_t                         bias_wr_addr,
    input  wire conv_pkg::bias_t                           bias_wr_data,
    input  wire conv_pkg::filter_t                         filter_sel,
    output conv_pkg::weight_t [conv_pkg::WINDOW_TAPS-1:0]  kernel,
    output conv_pkg::bias_t                                bias
);
    import conv_pkg::*;

    weight_t weights [NUM_FILTERS*WINDOW_TAPS];
    bias_t   biases  [NUM_FILTERS];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_FILTERS*WINDOW_TAPS; i++)
                weights[i] <= '0;
            for (int f = 0; f < NUM_FILTERS; f++)
                biases[f] <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_FILTERS*WINDOW_TAPS; i++)
                if (wt_wr_en && wt_wr_addr == wt_addr_t'(i))
                    weights[i] <= wt_wr_data;
            for (int f = 0; f < NUM_FILTERS; f++)
                if (bias_wr_en && bias_wr_addr == filter_t'(f))
                    biases[f] <= bias_wr_data;
        end
    end

    always_comb
    begin
        for (int k = 0; k < WINDOW_TAPS; k++)
            kernel[k] = weights[int'(filter_sel)*WINDOW_TAPS + k];
        bias = biases[filter_sel];  // current filter
    end

    // Loading only happens while the layer is idle
    no_load_on_switch: assert property (@(posedge clk) disable iff (reset)
        (wt_wr_en || bias_wr_en) |-> $stable(filter_sel));

endmodule

`default_nettype wire

//--- verilog/window_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module window_buffer
(
    input  wire                                           clk,
    input  wire                                           reset,
    input  wire conv_pkg::pixel_t                         pixel_in,
    input  wire                                           shift,
    output conv_pkg::pixel_t [conv_pkg::WINDOW_TAPS-1:0]  window
);
    import conv_pkg::*;

    // Index 0 holds the newest pixel
    pixel_t [LINE_DEPTH-1:0] line;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            line <= '0;
        else if (shift)
            line <= {line[LINE_DEPTH-2:0], pixel_in};
    end

    ////////////////////////////////////////////////////////////////////////////
    // Window taps
    ////////////////////////////////////////////////////////////////////////////

    // Tap ky*K+kx is row ky, column kx of the window, top left first.
    // The newest pixel sits at the bottom right, so the oldest stage in
    // the line is the top left tap.
    for (genvar ky = 0; ky < KERNEL_SIZE; ky++)
    begin : g_row
        for (genvar kx = 0; kx < KERNEL_SIZE; kx++)
        begin : g_col
            assign window[ky*KERNEL_SIZE + kx] = line[LINE_DEPTH-1 - ky*IFM_SIZE - kx];
        end
    end

endmodule

`default_nettype wire
